// ==== compile.f ====
+incdir+hdl
hdl/dbg_pkg.sv
hdl/key_decode.sv
hdl/step_ctrl.sv
hdl/retire_display.sv
hdl/dbg_monitor_top.sv
tb/clk_gen.sv
tb/dbg_monitor_properties.sv
tb/dbg_monitor_tb.sv

// ==== tb/dbg_monitor_tb.sv ====
/*
 * Debug monitor testbench
 * Plays the core under test, works the two keys and checks
 * LEDs and digits against a reference model of the monitor
 */

`include "dbg_macros.svh"

module dbg_monitor_tb
    import dbg_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 50;

    logic         clk;
    logic         i_rst_n;
    logic [1:0]   i_key;
    dbg_data_t    i_sim_tp;
    logic         i_retire_en;
    dbg_reg_idx_t i_retire_rdst;
    dbg_data_t    i_retire_data;
    logic         i_redirect;
    dbg_addr_t    i_redirect_addr;
    logic         o_core_en;
    logic         o_done;
    logic [17:0]  o_ledr;
    logic [4:0]   o_ledg;
    seg7_t        o_hex0, o_hex1, o_hex2, o_hex3, o_hex4, o_hex5, o_hex6, o_hex7;

    integer seed = 36;
    int     mismatches = 0;
    int     timeouts = 0;

    // ========================================
    // Reference model
    // ========================================
    step_state_t  model_state;
    logic         model_redirect;
    logic [15:0]  model_addr;
    dbg_reg_idx_t model_rdst;
    dbg_data_t    model_data;

    clk_gen clk_gen_inst (.o_clk(clk));

    dbg_monitor_top i_dut (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_key           (i_key),
        .i_sim_tp        (i_sim_tp),
        .i_retire_en     (i_retire_en),
        .i_retire_rdst   (i_retire_rdst),
        .i_retire_data   (i_retire_data),
        .i_redirect      (i_redirect),
        .i_redirect_addr (i_redirect_addr),
        .o_core_en       (o_core_en),
        .o_done          (o_done),
        .o_ledr          (o_ledr),
        .o_ledg          (o_ledg),
        .o_hex0          (o_hex0),
        .o_hex1          (o_hex1),
        .o_hex2          (o_hex2),
        .o_hex3          (o_hex3),
        .o_hex4          (o_hex4),
        .o_hex5          (o_hex5),
        .o_hex6          (o_hex6),
        .o_hex7          (o_hex7)
    );

    // Lit segments in gfedcba order, inverted for the active-low pins
    function automatic seg7_t expected_seg7(input logic [3:0] nibble);
        logic [6:0] lit;
        case (nibble)
            4'h0: lit = 7'h3f;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5b;
            4'h3: lit = 7'h4f;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6d;
            4'h6: lit = 7'h7d;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7f;
            4'h9: lit = 7'h6f;
            4'ha: lit = 7'h77;
            4'hb: lit = 7'h7c;
            4'hc: lit = 7'h39;
            4'hd: lit = 7'h5e;
            4'he: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    function automatic seg7_t digit_out(input int d);
        case (d)
            0: return o_hex0;
            1: return o_hex1;
            2: return o_hex2;
            3: return o_hex3;
            4: return o_hex4;
            5: return o_hex5;
            6: return o_hex6;
            default: return o_hex7;
        endcase
    endfunction

    function automatic dbg_data_t non_code(input dbg_data_t value);
        if (value == `DBG_PASS_CODE || value == `DBG_FAIL_CODE) begin
            return value ^ 32'h1;
        end
        return value;
    endfunction

    task automatic report_mismatch(input string msg);
        mismatches++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
    endtask

    task automatic check_display();
        logic  exp_en;
        seg7_t want;
        exp_en = (model_state == STEP_RUN) || (model_state == STEP_STEP);
        if (o_core_en !== exp_en) begin
            report_mismatch($sformatf("core enable %b, expected %b", o_core_en, exp_en));
        end
        if (o_done !== (model_state == STEP_DONE)) begin
            report_mismatch($sformatf("done %b in model state %s", o_done, model_state.name()));
        end
        if (o_ledr[17] !== exp_en) begin
            report_mismatch($sformatf("ledr[17] %b, expected %b", o_ledr[17], exp_en));
        end
        if (o_ledr[16] !== model_redirect) begin
            report_mismatch($sformatf("ledr[16] %b, expected %b", o_ledr[16], model_redirect));
        end
        if (o_ledr[15:0] !== model_addr) begin
            report_mismatch($sformatf("ledr[15:0] %h, expected %h", o_ledr[15:0], model_addr));
        end
        if (o_ledg !== model_rdst) begin
            report_mismatch($sformatf("ledg %h, expected %h", o_ledg, model_rdst));
        end
        for (int d = 0; d < `DBG_NUM_DIGITS; d++) begin
            want = expected_seg7(model_data[d*4 +: 4]);
            if (digit_out(d) !== want) begin
                report_mismatch($sformatf("digit %0d is %h, expected %h", d, digit_out(d), want));
            end
        end
    endtask

    // Core model idles with junk on the record fields
    task automatic idle_cycle();
        i_retire_en     = 1'b0;
        i_retire_rdst   = $random(seed);
        i_retire_data   = $random(seed);
        i_redirect      = $random(seed);
        i_redirect_addr = $random(seed);
        @(negedge clk);
    endtask

    task automatic retire_one();
        if (o_core_en) begin
            i_retire_en     = 1'b1;
            i_retire_rdst   = $random(seed);
            i_retire_data   = $random(seed);
            i_redirect      = $random(seed);
            i_redirect_addr = $random(seed);
            if (model_state == STEP_STEP) begin
                model_state    = STEP_HALT;
                model_redirect = i_redirect;
                model_addr     = i_redirect_addr[15:0];
                model_rdst     = i_retire_rdst;
                model_data     = i_retire_data;
            end
            @(negedge clk);
            i_retire_en = 1'b0;
        end else begin
            idle_cycle();
        end
        check_display();
    endtask

    task automatic press_key(input int idx, input step_state_t next);
        int   waited;
        logic exp_en;
        logic exp_done;
        exp_en   = (next == STEP_RUN) || (next == STEP_STEP);
        exp_done = (next == STEP_DONE);
        i_key[idx] = 1'b0;
        repeat (6) idle_cycle();
        i_key[idx] = 1'b1;
        model_state = next;
        waited = 0;
        while ((o_core_en !== exp_en || o_done !== exp_done) && waited < WAIT_LIMIT) begin
            idle_cycle();
            waited++;
        end
        if (waited >= WAIT_LIMIT) begin
            timeouts++;
            $display("Timeout: key %0d press never reached state %s", idx, next.name());
        end
        check_display();
    endtask

    task automatic apply_code(input dbg_data_t code);
        int waited;
        i_sim_tp = code;
        waited = 0;
        while (o_done !== 1'b1 && waited < WAIT_LIMIT) begin
            idle_cycle();
            waited++;
        end
        if (waited >= WAIT_LIMIT) begin
            timeouts++;
            $display("Timeout: test code %h never raised done", code);
        end
        model_state = STEP_DONE;
        // Data register follows the test port one edge into DONE
        idle_cycle();
        model_data = code;
        check_display();
        // Park the port before any resume
        i_sim_tp = non_code($random(seed));
        idle_cycle();
        model_data = i_sim_tp;
        check_display();
    endtask

    // ========================================
    // Stimulus
    // ========================================
    initial begin
        int gap;
        int assert_fails;
        i_rst_n         = 1'b0;
        i_key           = 2'b11;
        i_sim_tp        = '0;
        i_retire_en     = 1'b0;
        i_retire_rdst   = '0;
        i_retire_data   = '0;
        i_redirect      = 1'b0;
        i_redirect_addr = '0;
        model_state     = STEP_STEP;
        model_redirect  = 1'b0;
        model_addr      = '0;
        model_rdst      = '0;
        model_data      = '0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        for (int d = 0; d < `DBG_NUM_DIGITS; d++) begin
            if (digit_out(d) !== 7'h7f) begin
                report_mismatch($sformatf("digit %0d is %h during reset", d, digit_out(d)));
            end
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;
        @(negedge clk);
        check_display();

        // First retire halts from the reset state
        retire_one();

        repeat (20) begin
            press_key(0, STEP_STEP);
            retire_one();
        end

        press_key(1, STEP_RUN);
        repeat (10) begin
            gap = $random(seed) & 3;
            repeat (gap) idle_cycle();
            retire_one();
        end

        apply_code(`DBG_PASS_CODE);
        press_key(1, STEP_RUN);
        repeat (5) retire_one();

        apply_code(`DBG_FAIL_CODE);
        press_key(0, STEP_STEP);
        retire_one();

        assert_fails = i_dut.step_ctrl_inst.i_props.fail_count;
        $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, assert_fails);
        if (mismatches == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tb/dbg_monitor_properties.sv ====
/*
 * Step controller properties
 * Concurrent checks on how the state register moves
 * after a capture and holds in HALT and DONE
 */

module dbg_monitor_properties
    import dbg_pkg::*;
(
    input logic        clk,
    input logic        i_rst_n,
    input step_state_t i_state,
    input logic [1:0]  i_key_pulse,
    input logic        i_capture_en,
    input logic        i_done
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // Done stays up until a key is pressed
    done_holds: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_done && (i_key_pulse == 2'b00) |=> i_done)
        else begin
            fail_count = fail_count + 1;
            $error("Done dropped without a key pulse");
        end

    // A captured retire always parks the core
    capture_then_halt: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_capture_en |=> (i_state == STEP_HALT))
        else begin
            fail_count = fail_count + 1;
            $error("State is not HALT one cycle after a capture");
        end

    halt_holds: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_state == STEP_HALT) && (i_key_pulse == 2'b00) |=> (i_state == STEP_HALT))
        else begin
            fail_count = fail_count + 1;
            $error("State left HALT without a key pulse");
        end

endmodule

bind step_ctrl dbg_monitor_properties i_props (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_state      (state_r),
    .i_key_pulse  (i_key_pulse),
    .i_capture_en (o_capture_en),
    .i_done       (o_done)
);

// ==== tb/clk_gen.sv ====
/*
 * Testbench clock source
 * Free-running clock with a 4 ns period
 */

module clk_gen (
    output logic o_clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;
    end

endmodule

// ==== hdl/dbg_monitor_top.sv ====
/*
 * Debug monitor top
 * Key decode, step controller and retire display for a core
 * under test, with LED and seven-segment outputs
 */

`include "dbg_macros.svh"

module dbg_monitor_top
    import dbg_pkg::*;
(
    input  logic         clk,
    input  logic         i_rst_n,
    input  logic [1:0]   i_key,

    input  dbg_data_t    i_sim_tp,
    input  logic         i_retire_en,
    input  dbg_reg_idx_t i_retire_rdst,
    input  dbg_data_t    i_retire_data,
    input  logic         i_redirect,
    input  dbg_addr_t    i_redirect_addr,

    output logic         o_core_en,
    output logic         o_done,
    output logic [17:0]  o_ledr,
    output logic [4:0]   o_ledg,
    output seg7_t        o_hex0,
    output seg7_t        o_hex1,
    output seg7_t        o_hex2,
    output seg7_t        o_hex3,
    output seg7_t        o_hex4,
    output seg7_t        o_hex5,
    output seg7_t        o_hex6,
    output seg7_t        o_hex7
);

    logic         [1:0] key_pulse;
    logic         capture_en;
    logic         ledr_redirect;
    logic [15:0]  ledr_addr;
    dbg_reg_idx_t ledg;
    seg7_t        hex [0:`DBG_NUM_DIGITS-1];

    // ========================================
    // Decode
    // ========================================
    key_decode key_decode_inst (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_key       (i_key),
        .o_key_pulse (key_pulse)
    );

    // ========================================
    // Execute
    // ========================================
    step_ctrl step_ctrl_inst (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_key_pulse  (key_pulse),
        .i_sim_tp     (i_sim_tp),
        .i_retire_en  (i_retire_en),
        .o_core_en    (o_core_en),
        .o_capture_en (capture_en),
        .o_done       (o_done)
    );

    // ========================================
    // Result
    // ========================================
    retire_display retire_display_inst (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_capture_en    (capture_en),
        .i_done          (o_done),
        .i_sim_tp        (i_sim_tp),
        .i_retire_rdst   (i_retire_rdst),
        .i_retire_data   (i_retire_data),
        .i_redirect      (i_redirect),
        .i_redirect_addr (i_redirect_addr),
        .o_ledr_redirect (ledr_redirect),
        .o_ledr_addr     (ledr_addr),
        .o_ledg          (ledg),
        .o_hex           (hex)
    );

    // Core enable on the top red LED
    assign o_ledr = {o_core_en, ledr_redirect, ledr_addr};
    assign o_ledg = ledg;

    assign o_hex0 = hex[0];
    assign o_hex1 = hex[1];
    assign o_hex2 = hex[2];
    assign o_hex3 = hex[3];
    assign o_hex4 = hex[4];
    assign o_hex5 = hex[5];
    assign o_hex6 = hex[6];
    assign o_hex7 = hex[7];

endmodule

// ==== hdl/retire_display.sv ====
/*
 * Retire capture and display
 * Latches the retire record on a step, or the test port once done,
 * and drives eight seven-segment digits from the data register
 */

`include "dbg_macros.svh"

module retire_display
    import dbg_pkg::*;
(
    input  logic         clk,
    input  logic         i_rst_n,
    input  logic         i_capture_en,
    input  logic         i_done,
    input  dbg_data_t    i_sim_tp,
    input  dbg_reg_idx_t i_retire_rdst,
    input  dbg_data_t    i_retire_data,
    input  logic         i_redirect,
    input  dbg_addr_t    i_redirect_addr,
    output logic         o_ledr_redirect,
    output logic [15:0]  o_ledr_addr,
    output dbg_reg_idx_t o_ledg,
    output seg7_t        o_hex [0:`DBG_NUM_DIGITS-1]
);

    localparam seg7_t SEG7_DARK = 7'h7f;

    logic         redirect_r;
    logic [15:0]  redirect_addr_r;
    dbg_reg_idx_t rdst_r;
    dbg_data_t    data_r;
    dbg_data_t    data_next;
    logic         data_load;

    // Hex digit to active-low segments
    function automatic seg7_t hex_to_seg7(input logic [3:0] nibble);
        seg7_t seg;
        case (nibble)
            4'h0: seg = 7'h40;
            4'h1: seg = 7'h79;
            4'h2: seg = 7'h24;
            4'h3: seg = 7'h30;
            4'h4: seg = 7'h19;
            4'h5: seg = 7'h12;
            4'h6: seg = 7'h02;
            4'h7: seg = 7'h78;
            4'h8: seg = 7'h00;
            4'h9: seg = 7'h10;
            4'ha: seg = 7'h08;
            4'hb: seg = 7'h03;
            4'hc: seg = 7'h46;
            4'hd: seg = 7'h21;
            4'he: seg = 7'h06;
            default: seg = 7'h0e;
        endcase
        return seg;
    endfunction

    // ========================================
    // Capture registers
    // ========================================
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            redirect_r      <= 1'b0;
            redirect_addr_r <= '0;
            rdst_r          <= '0;
        end else if (i_capture_en) begin
            redirect_r      <= i_redirect;
            redirect_addr_r <= i_redirect_addr[15:0];
            rdst_r          <= i_retire_rdst;
        end
    end

    // Done shows the test code in place of retire data
    assign data_next = i_done ? i_sim_tp : i_retire_data;
    assign data_load = i_capture_en || i_done;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            data_r <= '0;
        end else if (data_load) begin
            data_r <= data_next;
        end
    end

    assign o_ledr_redirect = redirect_r;
    assign o_ledr_addr     = redirect_addr_r;
    assign o_ledg          = rdst_r;

    // ========================================
    // Digit decoders, nibble 0 on digit 0
    // ========================================
    for (genvar d = 0; d < `DBG_NUM_DIGITS; d++) begin : g_digit
        assign o_hex[d] = i_rst_n ? hex_to_seg7(data_r[d*4 +: 4]) : SEG7_DARK;
    end

endmodule

// ==== hdl/step_ctrl.sv ====
/*
 * Step controller
 * Run, step, halt and done state machine worked by the keys
 * Produces the core enable, the capture strobe and the done level
 */

`include "dbg_macros.svh"

module step_ctrl
    import dbg_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst_n,
    input  logic [1:0] i_key_pulse,
    input  dbg_data_t i_sim_tp,
    input  logic      i_retire_en,
    output logic      o_core_en,
    output logic      o_capture_en,
    output logic      o_done
);

    step_state_t state_r;
    step_state_t state_next;
    logic        test_finished;
    logic        key_step;
    logic        key_run;

    assign key_step = i_key_pulse[0];
    assign key_run  = i_key_pulse[1];

    // Core reports either pass or fail on its test port
    assign test_finished = (i_sim_tp == `DBG_PASS_CODE) || (i_sim_tp == `DBG_FAIL_CODE);

    // ========================================
    // Next state
    // ========================================
    always_comb begin
        state_next = state_r;
        unique case (state_r)
            STEP_RUN: begin
                if (test_finished) begin
                    state_next = STEP_DONE;
                end else if (key_run) begin
                    state_next = STEP_STEP;
                end
            end
            STEP_STEP: begin
                if (i_retire_en) begin
                    state_next = STEP_HALT;
                end
            end
            STEP_HALT, STEP_DONE: begin
                if (key_run) begin
                    state_next = STEP_RUN;
                end else if (key_step) begin
                    state_next = STEP_STEP;
                end
            end
            default: state_next = STEP_STEP;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r <= STEP_STEP;
        end else begin
            state_r <= state_next;
        end
    end

    // Outputs decoded from the state
    assign o_core_en    = (state_r == STEP_RUN) || (state_r == STEP_STEP);
    assign o_capture_en = (state_r == STEP_STEP) && i_retire_en;
    assign o_done       = (state_r == STEP_DONE);

endmodule

// ==== hdl/key_decode.sv ====
/*
 * Key decode
 * Synchronizes the active-low push keys and turns
 * each press into a single one-cycle pulse
 */

`include "dbg_macros.svh"

module key_decode (
    input  logic       clk,
    input  logic       i_rst_n,
    input  logic [1:0] i_key,
    output logic [1:0] o_key_pulse
);

    localparam int SYNC_LAST = `DBG_SYNC_DEPTH - 1;

    logic [1:0] key_pressed;
    logic [1:0] sync_r [`DBG_SYNC_DEPTH];
    logic [1:0] key_last_r;
    logic [1:0] pulse_r;

    // Keys pull low when pressed
    assign key_pressed = ~i_key;

    // ========================================
    // Synchronizer chain
    // ========================================
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `DBG_SYNC_DEPTH; i++) begin
                sync_r[i] <= '0;
            end
        end else begin
            sync_r[0] <= key_pressed;
            for (int i = 1; i < `DBG_SYNC_DEPTH; i++) begin
                sync_r[i] <= sync_r[i-1];
            end
        end
    end

    // ========================================
    // Rising edge of the pressed level
    // ========================================
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            key_last_r <= '0;
            pulse_r    <= '0;
        end else begin
            key_last_r <= sync_r[SYNC_LAST];
            // A held key stays high in key_last_r, so no repeat pulse
            pulse_r    <= sync_r[SYNC_LAST] & ~key_last_r;
        end
    end

    assign o_key_pulse = pulse_r;

endmodule

// ==== hdl/dbg_pkg.sv ====
/*
 * Debug monitor package
 * Vector types for the retire record and the display,
 * and the state encoding of the step controller
 */

`include "dbg_macros.svh"

package dbg_pkg;

    typedef logic [`DBG_DATA_WIDTH-1:0]    dbg_data_t;
    typedef logic [`DBG_ADDR_WIDTH-1:0]    dbg_addr_t;
    typedef logic [`DBG_REG_IDX_WIDTH-1:0] dbg_reg_idx_t;

    // Active-low segments, bit 0 is a, bit 6 is g
    typedef logic [6:0] seg7_t;

    // ========================================
    // Step controller states
    // ========================================
    typedef enum logic [1:0] {
        STEP_RUN  = 2'b00,
        STEP_STEP = 2'b01,
        STEP_HALT = 2'b10,
        STEP_DONE = 2'b11
    } step_state_t;

endpackage

// ==== hdl/dbg_macros.svh ====
/*
 * Debug monitor macros
 * Widths of the retire record, test port codes,
 * key synchronizer depth and display digit count
 */

`ifndef DBG_MACROS_SVH
`define DBG_MACROS_SVH

// ========================================
// Retire record widths
// ========================================
`define DBG_DATA_WIDTH     32
`define DBG_ADDR_WIDTH     32
`define DBG_REG_IDX_WIDTH  5

// Key synchronizer flop count
`define DBG_SYNC_DEPTH     2

// Codes the core writes to its test port
`define DBG_PASS_CODE      32'h0000_4a33
`define DBG_FAIL_CODE      32'h0000_fae1

`define DBG_NUM_DIGITS     8

`endif
